//--- run.sh
#!/bin/sh
# Build and run the branch predictor testbench with Verilator.
# The simulator exits non-zero on any $fatal, which fails this script.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_branch_predictor \
	-f src.f \
	-o sim_tb_branch_predictor

./obj_dir/sim_tb_branch_predictor

//--- src.f
src/bp_pkg.sv
src/pred_table.sv
src/btb.sv
src/bht.sv
src/next_pc_select.sv
src/branch_predictor.sv
tests/tb_branch_predictor.sv

//--- src/bht.sv
`timescale 1ns/1ps

// Branch history table of 2-bit saturating counters.
// The counter update is a read-modify-write: the current value comes from
// a second table one cycle after the resolution, so the write lands one
// edge later and is bypassed to lookups and back-to-back resolutions.
module bht (
	input  logic          i_clk,        // Global clock, rising edge.
	input  logic          i_reset,      // Asynchronous reset, active low.
	input  bp_pkg::addr_t i_fetch_pc,   // Lookup address.
	input  logic          i_res_valid,  // Control transfer resolved this cycle.
	input  logic          i_res_taken,  // Resolved direction.
	input  bp_pkg::addr_t i_res_pc,     // PC of the resolving instruction.
	output logic          o_taken       // Predicted direction.
);

logic [bp_pkg::BHT_INDEX_W-1:0] fetch_index;  // Lookup index, PC[9:2].
logic [bp_pkg::BHT_INDEX_W-1:0] res_index;    // Resolve index.
logic [bp_pkg::BHT_INDEX_W-1:0] upd_index_q;  // Index of the pending update.
logic                           upd_valid_q;  // Update pending this cycle.
logic                           upd_taken_q;  // Direction of the pending update.
logic                           cur_fwd_q;    // Pending write hits the resolve read.
logic                           lk_fwd_q;     // Pending write hits the lookup read.
bp_pkg::ctr_t                   ctr_fwd_q;    // Counter value just written.
bp_pkg::ctr_t                   rd_ctr;       // Lookup table output.
bp_pkg::ctr_t                   cur_rd_ctr;   // Resolve table output.
bp_pkg::ctr_t                   cur_ctr;      // Current counter at the update index.
bp_pkg::ctr_t                   lk_ctr;       // Counter seen by the lookup.
bp_pkg::ctr_t                   new_ctr;      // Counter after one step.

assign fetch_index = i_fetch_pc[bp_pkg::PC_LSB +: bp_pkg::BHT_INDEX_W];
assign res_index   = i_res_pc[bp_pkg::PC_LSB +: bp_pkg::BHT_INDEX_W];

always_ff @(posedge i_clk or negedge i_reset) begin
	if (~i_reset) begin
		upd_valid_q <= 1'b0;
		upd_taken_q <= 1'b0;
		upd_index_q <= '0;
		cur_fwd_q   <= 1'b0;
		lk_fwd_q    <= 1'b0;
	end else begin
		upd_valid_q <= i_res_valid;             // Every resolution trains.
		upd_taken_q <= i_res_taken;
		upd_index_q <= res_index;
		cur_fwd_q   <= upd_valid_q & (upd_index_q == res_index);   // Back-to-back same index.
		lk_fwd_q    <= upd_valid_q & (upd_index_q == fetch_index); // Lookup after resolve.
	end
end

always_ff @(posedge i_clk) begin
	ctr_fwd_q <= new_ctr;                      // Copy of the value being written.
end

assign cur_ctr = cur_fwd_q ? ctr_fwd_q : cur_rd_ctr;
assign lk_ctr  = lk_fwd_q ? ctr_fwd_q : rd_ctr;

// One step toward the resolved direction, saturating at both ends.
always_comb begin
	case (cur_ctr)
		bp_pkg::CTR_STRONG_NT: new_ctr = upd_taken_q ? bp_pkg::CTR_WEAK_NT : bp_pkg::CTR_STRONG_NT;
		bp_pkg::CTR_WEAK_NT:   new_ctr = upd_taken_q ? bp_pkg::CTR_WEAK_T : bp_pkg::CTR_STRONG_NT;
		bp_pkg::CTR_WEAK_T:    new_ctr = upd_taken_q ? bp_pkg::CTR_STRONG_T : bp_pkg::CTR_WEAK_NT;
		default:               new_ctr = upd_taken_q ? bp_pkg::CTR_STRONG_T : bp_pkg::CTR_WEAK_T;
	endcase
end

pred_table #(
	.INDEX_W     (bp_pkg::BHT_INDEX_W),
	.payload_t   (bp_pkg::ctr_t),
	.RESET_VALUE (bp_pkg::CTR_RESET)
) u_lookup_table (
	.i_clk      (i_clk),
	.i_reset    (i_reset),
	.i_rd_index (fetch_index),                 // Read by the fetch PC.
	.i_wr_index (upd_index_q),
	.i_wr_en    (upd_valid_q),
	.i_wr_data  (new_ctr),
	.o_rd_data  (rd_ctr)
);

pred_table #(
	.INDEX_W     (bp_pkg::BHT_INDEX_W),
	.payload_t   (bp_pkg::ctr_t),
	.RESET_VALUE (bp_pkg::CTR_RESET)
) u_update_table (
	.i_clk      (i_clk),
	.i_reset    (i_reset),
	.i_rd_index (res_index),                   // Read by the resolve PC.
	.i_wr_index (upd_index_q),                 // Same writes as the lookup copy.
	.i_wr_en    (upd_valid_q),
	.i_wr_data  (new_ctr),
	.o_rd_data  (cur_rd_ctr)
);

assign o_taken = lk_ctr[1];                    // MSB set predicts taken.

endmodule

//--- src/bp_pkg.sv
package bp_pkg;

	// Address and instruction geometry.
	localparam int XLEN        = 32;            // Instruction address width.
	localparam int PC_LSB      = 2;             // Lowest PC bit above the byte offset.

	// Table sizes.
	localparam int BTB_INDEX_W = 6;             // 64 BTB entries, PC[7:2].
	localparam int BHT_INDEX_W = 8;             // 256 counters, PC[9:2].
	localparam int BTB_TAG_W   = XLEN - BTB_INDEX_W - PC_LSB; // PC bits above the BTB index.

	typedef logic [XLEN-1:0] addr_t;            // Instruction address.

	// One BTB entry, 57 bits.
	typedef struct packed {
		logic                 valid;             // Entry holds a taken branch.
		logic [BTB_TAG_W-1:0] tag;               // Upper PC bits of the branch.
		addr_t                target;            // Last resolved target.
	} btb_entry_t;

	// 2-bit saturating counter, MSB set predicts taken.
	typedef logic [1:0] ctr_t;

	localparam ctr_t CTR_STRONG_NT = 2'd0;      // Strongly not taken.
	localparam ctr_t CTR_WEAK_NT   = 2'd1;      // Weakly not taken.
	localparam ctr_t CTR_WEAK_T    = 2'd2;      // Weakly taken.
	localparam ctr_t CTR_STRONG_T  = 2'd3;      // Strongly taken.
	localparam ctr_t CTR_RESET     = CTR_WEAK_NT; // Counter value after reset.

	localparam addr_t INSN_BYTES   = 32'd4;     // Fall-through step.

endpackage

//--- src/branch_predictor.sv
`timescale 1ns/1ps

// Branch prediction unit: BTB and BHT looked up in parallel by the fetch PC,
// trained by resolved control transfers from the execute stage.
module branch_predictor (
	input  logic          i_clk,              // Global clock, rising edge.
	input  logic          i_reset,            // Asynchronous reset, active low.

	// Fetch side.
	input  logic          i_fetch_valid,      // Lookup request.
	input  bp_pkg::addr_t i_fetch_pc,         // Lookup address.

	// Resolve side, from execute.
	input  logic          i_res_valid,        // Control transfer resolved.
	input  bp_pkg::addr_t i_res_pc,           // PC of the resolving instruction.
	input  logic          i_res_taken,        // Resolved direction.
	input  bp_pkg::addr_t i_res_target,       // Resolved target.
	input  logic          i_res_pred_taken,   // Direction it was predicted with.
	input  bp_pkg::addr_t i_res_pred_target,  // Target it was predicted with.

	// Lookup results, one cycle after the request.
	output logic          o_pred_valid,       // Result valid.
	output logic          o_pred_taken,       // Predicted taken.
	output bp_pkg::addr_t o_pred_pc,          // Predicted next PC.

	// Correction, one cycle after the resolution.
	output logic          o_redirect,         // Misprediction.
	output bp_pkg::addr_t o_redirect_pc       // Corrected PC.
);

logic          btb_hit;       // BTB tag match.
bp_pkg::addr_t btb_target;    // BTB stored target.
logic          bht_taken;     // Counter direction.

btb u_btb (
	.i_clk        (i_clk),
	.i_reset      (i_reset),
	.i_fetch_pc   (i_fetch_pc),
	.i_res_valid  (i_res_valid),
	.i_res_taken  (i_res_taken),
	.i_res_pc     (i_res_pc),
	.i_res_target (i_res_target),
	.o_hit        (btb_hit),
	.o_target     (btb_target)
);

bht u_bht (
	.i_clk       (i_clk),
	.i_reset     (i_reset),
	.i_fetch_pc  (i_fetch_pc),
	.i_res_valid (i_res_valid),
	.i_res_taken (i_res_taken),
	.i_res_pc    (i_res_pc),
	.o_taken     (bht_taken)
);

next_pc_select u_next_pc_select (
	.i_clk             (i_clk),
	.i_reset           (i_reset),
	.i_fetch_valid     (i_fetch_valid),
	.i_fetch_pc        (i_fetch_pc),
	.i_btb_hit         (btb_hit),
	.i_bht_taken       (bht_taken),
	.i_btb_target      (btb_target),
	.i_res_valid       (i_res_valid),
	.i_res_taken       (i_res_taken),
	.i_res_pred_taken  (i_res_pred_taken),
	.i_res_pc          (i_res_pc),
	.i_res_target      (i_res_target),
	.i_res_pred_target (i_res_pred_target),
	.o_pred_valid      (o_pred_valid),
	.o_pred_taken      (o_pred_taken),
	.o_pred_pc         (o_pred_pc),
	.o_redirect        (o_redirect),
	.o_redirect_pc     (o_redirect_pc)
);

endmodule

//--- src/btb.sv
`timescale 1ns/1ps

// Branch target buffer.
// Direct mapped, tagged, allocates on taken resolutions only.
module btb (
	input  logic          i_clk,         // Global clock, rising edge.
	input  logic          i_reset,       // Asynchronous reset, active low.
	input  bp_pkg::addr_t i_fetch_pc,    // Lookup address.
	input  logic          i_res_valid,   // Control transfer resolved this cycle.
	input  logic          i_res_taken,   // Resolved direction.
	input  bp_pkg::addr_t i_res_pc,      // PC of the resolving instruction.
	input  bp_pkg::addr_t i_res_target,  // Resolved target.
	output logic          o_hit,         // Valid entry with matching tag.
	output bp_pkg::addr_t o_target       // Stored target of the entry.
);

logic [bp_pkg::BTB_INDEX_W-1:0] fetch_index;   // Lookup index, PC[7:2].
logic [bp_pkg::BTB_INDEX_W-1:0] res_index;     // Allocation index.
logic [bp_pkg::BTB_TAG_W-1:0]   fetch_tag;     // Upper bits of the lookup PC.
logic [bp_pkg::BTB_TAG_W-1:0]   fetch_tag_q;   // Tag lined up with the table read.
logic                           alloc;         // Write a new entry.
bp_pkg::btb_entry_t             wr_entry;      // Entry being written.
bp_pkg::btb_entry_t             rd_entry;      // Entry read for the lookup.

assign fetch_index = i_fetch_pc[bp_pkg::PC_LSB +: bp_pkg::BTB_INDEX_W];
assign res_index   = i_res_pc[bp_pkg::PC_LSB +: bp_pkg::BTB_INDEX_W];
assign fetch_tag   = i_fetch_pc[bp_pkg::XLEN-1 -: bp_pkg::BTB_TAG_W];

assign alloc = i_res_valid & i_res_taken;       // Not-taken branches keep the old entry.

assign wr_entry.valid  = 1'b1;
assign wr_entry.tag    = i_res_pc[bp_pkg::XLEN-1 -: bp_pkg::BTB_TAG_W];
assign wr_entry.target = i_res_target;

always_ff @(posedge i_clk) begin
	fetch_tag_q <= fetch_tag;                  // Compare against the registered read.
end

pred_table #(
	.INDEX_W     (bp_pkg::BTB_INDEX_W),
	.payload_t   (bp_pkg::btb_entry_t),
	.RESET_VALUE ('0)                          // All entries invalid.
) u_table (
	.i_clk      (i_clk),
	.i_reset    (i_reset),
	.i_rd_index (fetch_index),
	.i_wr_index (res_index),
	.i_wr_en    (alloc),
	.i_wr_data  (wr_entry),
	.o_rd_data  (rd_entry)
);

assign o_hit    = rd_entry.valid & (rd_entry.tag == fetch_tag_q); // Aliases miss.
assign o_target = rd_entry.target;

endmodule

//--- src/next_pc_select.sv
`timescale 1ns/1ps

// Next-PC selection for the fetch side and misprediction check for the
// resolve side. Both paths give their results one edge after sampling.
module next_pc_select (
	input  logic          i_clk,              // Global clock, rising edge.
	input  logic          i_reset,            // Asynchronous reset, active low.
	input  logic          i_fetch_valid,      // Lookup request.
	input  bp_pkg::addr_t i_fetch_pc,         // Lookup address.
	input  logic          i_btb_hit,          // BTB entry matched.
	input  logic          i_bht_taken,        // Counter predicts taken.
	input  bp_pkg::addr_t i_btb_target,       // BTB target.
	input  logic          i_res_valid,        // Control transfer resolved this cycle.
	input  logic          i_res_taken,        // Resolved direction.
	input  logic          i_res_pred_taken,   // Direction that was predicted.
	input  bp_pkg::addr_t i_res_pc,           // PC of the resolving instruction.
	input  bp_pkg::addr_t i_res_target,       // Resolved target.
	input  bp_pkg::addr_t i_res_pred_target,  // Target that was predicted.
	output logic          o_pred_valid,       // Lookup result valid.
	output logic          o_pred_taken,       // Predicted taken.
	output bp_pkg::addr_t o_pred_pc,          // Predicted next PC.
	output logic          o_redirect,         // Misprediction, refetch needed.
	output bp_pkg::addr_t o_redirect_pc       // Corrected PC.
);

logic          pred_valid_q;    // Fetch valid lined up with the table reads.
bp_pkg::addr_t fetch_pc_q;      // Fetch PC lined up with the table reads.
bp_pkg::addr_t fall_through;    // Sequential next PC.
logic          dir_wrong;       // Direction mispredicted.
logic          target_wrong;    // Taken both ways, but to another address.
logic          redirect_q;      // Registered misprediction flag.
bp_pkg::addr_t redirect_pc_q;   // Registered corrected PC.

assign dir_wrong    = i_res_taken ^ i_res_pred_taken;
assign target_wrong = i_res_taken & i_res_pred_taken & (i_res_target != i_res_pred_target);

always_ff @(posedge i_clk or negedge i_reset) begin
	if (~i_reset) begin
		pred_valid_q <= 1'b0;
		redirect_q   <= 1'b0;
	end else begin
		pred_valid_q <= i_fetch_valid;
		redirect_q   <= i_res_valid & (dir_wrong | target_wrong);
	end
end

always_ff @(posedge i_clk) begin
	fetch_pc_q <= i_fetch_pc;
	// Taken goes to the resolved target, not taken falls through.
	redirect_pc_q <= i_res_taken ? i_res_target : i_res_pc + bp_pkg::INSN_BYTES;
end

assign fall_through = fetch_pc_q + bp_pkg::INSN_BYTES;

// Taken needs both a BTB hit and a taken counter.
assign o_pred_taken  = i_btb_hit & i_bht_taken;
assign o_pred_pc     = o_pred_taken ? i_btb_target : fall_through;
assign o_pred_valid  = pred_valid_q;
assign o_redirect    = redirect_q;
assign o_redirect_pc = redirect_pc_q;

endmodule

//--- src/pred_table.sv
`timescale 1ns/1ps

// Indexed storage shared by the BTB and the BHT.
// One write port, one registered read port.
module pred_table #(
	parameter int       INDEX_W     = 4,            // Index width, depth is 2**INDEX_W.
	parameter type      payload_t   = logic [7:0],  // Stored entry type.
	parameter payload_t RESET_VALUE = '0            // Value of every entry after reset.
) (
	input  logic               i_clk,       // Global clock, rising edge.
	input  logic               i_reset,     // Asynchronous reset, active low.
	input  logic [INDEX_W-1:0] i_rd_index,  // Read address, sampled on the edge.
	input  logic [INDEX_W-1:0] i_wr_index,  // Write address.
	input  logic               i_wr_en,     // Write enable.
	input  payload_t           i_wr_data,   // Write data.
	output payload_t           o_rd_data    // Read data, one cycle after the address.
);

localparam int DEPTH = 2 ** INDEX_W;       // Number of entries.

payload_t mem [DEPTH];                     // Table storage.

// Write and read share the edge.
// The read register samples the contents before the write lands,
// so a same-edge write shows up on the next read.
always_ff @(posedge i_clk or negedge i_reset) begin
	if (~i_reset) begin
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] <= RESET_VALUE;           // Clear every entry.
		end
		o_rd_data <= RESET_VALUE;            // Read port starts at the reset value.
	end else begin
		if (i_wr_en) begin
			mem[i_wr_index] <= i_wr_data;    // Update one entry.
		end
		o_rd_data <= mem[i_rd_index];        // Old contents on a same-edge write.
	end
end

endmodule

//--- tests/bp_vectors.txt
# name, then inputs: fetch_valid fetch_pc res_valid res_pc res_taken res_target pred_taken pred_target
# then expected after the edge: pred_valid pred_taken pred_pc redirect redirect_pc (all hex)
reset_idle 0 00000000 0 00000000 0 00000000 0 00000000 0 0 00000000 0 00000000
reset_idle 0 00000000 0 00000000 0 00000000 0 00000000 0 0 00000000 0 00000000
reset_lookup 1 00001000 0 00000000 0 00000000 0 00000000 1 0 00001004 0 00000000
reset_lookup 1 00000ff0 0 00000000 0 00000000 0 00000000 1 0 00000ff4 0 00000000
reset_lookup 1 fffffffc 0 00000000 0 00000000 0 00000000 1 0 00000000 0 00000000
train 0 00000000 1 00001000 1 00002000 0 00000000 0 0 00000000 1 00002000
train 1 00001000 0 00000000 0 00000000 0 00000000 1 1 00002000 0 00000000
sat_high 0 00000000 1 00000040 1 00000100 0 00000000 0 0 00000000 1 00000100
sat_high 1 00000040 1 00000040 1 00000100 1 00000100 1 1 00000100 0 00000100
sat_high 1 00000040 1 00000040 1 00000100 1 00000100 1 1 00000100 0 00000100
sat_down 1 00000040 1 00000040 0 00000000 1 00000100 1 1 00000100 1 00000044
sat_down 1 00000040 0 00000000 0 00000000 0 00000000 1 1 00000100 0 00000000
sat_down 1 00000040 1 00000040 0 00000000 1 00000100 1 1 00000100 1 00000044
sat_down 1 00000040 0 00000000 0 00000000 0 00000000 1 0 00000044 0 00000000
sat_low 0 00000000 1 00000040 0 00000000 0 00000000 0 0 00000000 0 00000044
sat_low 0 00000000 1 00000040 0 00000000 0 00000000 0 0 00000000 0 00000044
sat_low 0 00000000 1 00000040 1 00000100 0 00000000 0 0 00000000 1 00000100
sat_low 1 00000040 0 00000000 0 00000000 0 00000000 1 0 00000044 0 00000000
sat_low 0 00000000 1 00000040 1 00000100 0 00000000 0 0 00000000 1 00000100
sat_low 1 00000040 0 00000000 0 00000000 0 00000000 1 1 00000100 0 00000000
alias_miss 1 00001400 0 00000000 0 00000000 0 00000000 1 0 00001404 0 00000000
alias_miss 1 00001000 0 00000000 0 00000000 0 00000000 1 1 00002000 0 00000000
alias_miss 0 00000000 1 00001400 1 00003000 0 00000000 0 0 00000000 1 00003000
alias_miss 1 00001000 0 00000000 0 00000000 0 00000000 1 0 00001004 0 00000000
alias_miss 1 00001400 0 00000000 0 00000000 0 00000000 1 1 00003000 0 00000000
redir_taken 0 00000000 1 00000080 1 00000200 0 00000000 0 0 00000000 1 00000200
redir_not_taken 0 00000000 1 000000c0 0 00000000 1 00000300 0 0 00000000 1 000000c4
redir_target 0 00000000 1 00000080 1 00000240 1 00000200 0 0 00000000 1 00000240
redir_correct 0 00000000 1 00000080 1 00000240 1 00000240 0 0 00000000 0 00000240
redir_correct 0 00000000 1 000000c0 0 00000000 0 00000000 0 0 00000000 0 000000c4
redir_correct 1 00000080 0 00000000 0 00000000 0 00000000 1 1 00000240 0 00000000
same_edge 1 00000010 1 00000010 1 00000500 0 00000000 1 0 00000014 1 00000500
same_edge 1 00000010 0 00000000 0 00000000 0 00000000 1 1 00000500 0 00000000
same_edge 1 00000010 1 00000010 0 00000000 1 00000500 1 1 00000500 1 00000014
same_edge 1 00000010 0 00000000 0 00000000 0 00000000 1 0 00000014 0 00000000
same_edge 1 00000010 1 00000010 1 00000500 0 00000000 1 0 00000014 1 00000500
same_edge 1 00000010 1 00000010 1 00000500 1 00000500 1 1 00000500 0 00000500
same_edge 1 00000010 1 00000010 0 00000000 1 00000500 1 1 00000500 1 00000014
same_edge 1 00000010 0 00000000 0 00000000 0 00000000 1 1 00000500 0 00000000
mixed 1 00000080 1 000000c0 1 00000300 0 00000000 1 1 00000240 1 00000300
mixed 1 000000c0 1 000000c0 1 00000300 0 00000000 1 0 000000c4 1 00000300
mixed 1 000000c0 0 00000000 0 00000000 0 00000000 1 1 00000300 0 00000000
mixed 1 00000040 0 00000000 0 00000000 0 00000000 1 1 00000100 0 00000000
mixed 1 00000ff0 0 00000000 0 00000000 0 00000000 1 0 00000ff4 0 00000000
mixed 0 00000000 0 00000000 0 00000000 0 00000000 0 0 00000000 0 00000000

//--- tests/tb_branch_predictor.sv
`timescale 1ns/1ps

// Self-checking testbench for the branch predictor.
// Replays one vector line per cycle and checks the results one edge later.
module tb_branch_predictor;

localparam int MAX_VECS   = 128;  // Room in the vector arrays.
localparam int CLK_HALF   = 50;   // Half clock period in ns.
localparam int CLK_PERIOD = 100;  // Clock period in ns.

logic          i_clk;              // DUT clock.
logic          i_reset;            // Active-low DUT reset.
logic          i_fetch_valid;
bp_pkg::addr_t i_fetch_pc;
logic          i_res_valid;
bp_pkg::addr_t i_res_pc;
logic          i_res_taken;
bp_pkg::addr_t i_res_target;
logic          i_res_pred_taken;
bp_pkg::addr_t i_res_pred_target;
logic          o_pred_valid;
logic          o_pred_taken;
bp_pkg::addr_t o_pred_pc;
logic          o_redirect;
bp_pkg::addr_t o_redirect_pc;

// One entry per vector line and one array per column.
logic [8*24-1:0] vec_name  [MAX_VECS];  // Test name.
logic [31:0]     vec_fv    [MAX_VECS];  // Fetch valid.
logic [31:0]     vec_fpc   [MAX_VECS];  // Fetch PC.
logic [31:0]     vec_rv    [MAX_VECS];  // Resolve valid.
logic [31:0]     vec_rpc   [MAX_VECS];  // Resolve PC.
logic [31:0]     vec_rtk   [MAX_VECS];  // Resolved taken.
logic [31:0]     vec_rtgt  [MAX_VECS];  // Resolved target.
logic [31:0]     vec_rptk  [MAX_VECS];  // Predicted taken carried down the pipeline.
logic [31:0]     vec_rptgt [MAX_VECS];  // Predicted target carried down the pipeline.
logic [31:0]     vec_epv   [MAX_VECS];  // Expected o_pred_valid.
logic [31:0]     vec_ept   [MAX_VECS];  // Expected o_pred_taken.
logic [31:0]     vec_eppc  [MAX_VECS];  // Expected o_pred_pc.
logic [31:0]     vec_erd   [MAX_VECS];  // Expected o_redirect.
logic [31:0]     vec_erpc  [MAX_VECS];  // Expected o_redirect_pc.

int   num_vecs;        // Vector lines read.
logic vectors_loaded;  // Starts the watchdog.

branch_predictor DUT (
	.i_clk             (i_clk),
	.i_reset           (i_reset),
	.i_fetch_valid     (i_fetch_valid),
	.i_fetch_pc        (i_fetch_pc),
	.i_res_valid       (i_res_valid),
	.i_res_pc          (i_res_pc),
	.i_res_taken       (i_res_taken),
	.i_res_target      (i_res_target),
	.i_res_pred_taken  (i_res_pred_taken),
	.i_res_pred_target (i_res_pred_target),
	.o_pred_valid      (o_pred_valid),
	.o_pred_taken      (o_pred_taken),
	.o_pred_pc         (o_pred_pc),
	.o_redirect        (o_redirect),
	.o_redirect_pc     (o_redirect_pc)
);

always #CLK_HALF i_clk = ~i_clk;  // 100 ns period.

// Reads the vector file and skips comment and blank lines.
task automatic load_vectors();
	int    fd;
	int    count;
	string line;
	fd = $fopen("tests/bp_vectors.txt", "r");
	if (fd == 0) begin
		$display("Could not open the vector file tests/bp_vectors.txt.");
		$display("TEST FAILED");
		$fatal(1, "No vectors.");
	end else begin
		while ($fgets(line, fd) != 0) begin
			if (line.len() > 1 && line.getc(0) != "#") begin
				if (num_vecs == MAX_VECS) begin
					$display("The vector file holds more lines than the testbench can store.");
					$display("TEST FAILED");
					$fatal(1, "Too many vectors.");
				end
				count = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h",
					vec_name[num_vecs], vec_fv[num_vecs], vec_fpc[num_vecs],
					vec_rv[num_vecs], vec_rpc[num_vecs], vec_rtk[num_vecs],
					vec_rtgt[num_vecs], vec_rptk[num_vecs], vec_rptgt[num_vecs],
					vec_epv[num_vecs], vec_ept[num_vecs], vec_eppc[num_vecs],
					vec_erd[num_vecs], vec_erpc[num_vecs]);
				if (count != 14) begin
					$display("A vector line could not be parsed: %0s", line);
					$display("TEST FAILED");
					$fatal(1, "Bad vector line.");
				end
				num_vecs++;
			end
		end
		$fclose(fd);
	end
endtask

// All request lines low and payloads zero.
task automatic idle_inputs();
	i_fetch_valid     = 1'b0;
	i_fetch_pc        = '0;
	i_res_valid       = 1'b0;
	i_res_pc          = '0;
	i_res_taken       = 1'b0;
	i_res_target      = '0;
	i_res_pred_taken  = 1'b0;
	i_res_pred_target = '0;
endtask

// Apply one vector line; fields that cannot matter get random values.
task automatic drive_vector(input int k);
	logic [31:0] rnd;
	rnd               = $urandom();
	i_fetch_valid     = vec_fv[k][0];
	i_fetch_pc        = vec_fpc[k];
	i_res_valid       = vec_rv[k][0];
	i_res_pc          = vec_rpc[k];
	i_res_taken       = vec_rtk[k][0];
	i_res_target      = vec_rtgt[k];
	i_res_pred_taken  = vec_rptk[k][0];
	i_res_pred_target = vec_rptgt[k];
	if (!vec_fv[k][0]) begin
		i_fetch_pc = $urandom();                  // No lookup this cycle.
	end
	if (!vec_rv[k][0]) begin
		i_res_pc         = $urandom();            // No resolution this cycle.
		i_res_taken      = rnd[0];
		i_res_pred_taken = rnd[1];
	end
	if (!(i_res_valid && i_res_taken)) begin
		i_res_target = $urandom();                // Target unused when not taken.
	end
	if (!(i_res_taken && i_res_pred_taken)) begin
		i_res_pred_target = $urandom();           // Only compared when both taken.
	end
endtask

// One value check.
task automatic compare_field(input logic [8*24-1:0] name, input string field,
	input logic [31:0] expected, input logic [31:0] actual);
	assert (actual === expected) else begin
		$display("[ERROR] %0s: %0s expected %h, actual %h", name, field, expected, actual);
		$display("TEST FAILED");
		$fatal(1, "Value mismatch.");
	end
endtask

// Checks the results of line k between its edge and the next.
task automatic check_vector(input int k);
	compare_field(vec_name[k], "o_pred_valid", vec_epv[k], 32'(o_pred_valid));
	if (vec_epv[k][0]) begin
		compare_field(vec_name[k], "o_pred_taken", vec_ept[k], 32'(o_pred_taken));
		compare_field(vec_name[k], "o_pred_pc", vec_eppc[k], o_pred_pc);
	end
	compare_field(vec_name[k], "o_redirect", vec_erd[k], 32'(o_redirect));
	if (vec_rv[k][0]) begin
		compare_field(vec_name[k], "o_redirect_pc", vec_erpc[k], o_redirect_pc);
	end
endtask

initial begin
	void'($urandom(4219));               // Fixed seed.
	i_clk          = 1'b0;
	i_reset        = 1'b0;               // Reset held from time zero.
	num_vecs       = 0;
	vectors_loaded = 1'b0;
	idle_inputs();
	load_vectors();
	vectors_loaded = 1'b1;
	repeat (2) @(posedge i_clk);
	#1;
	i_reset = 1'b1;
	compare_field("reset", "o_pred_valid", 32'd0, 32'(o_pred_valid));
	compare_field("reset", "o_redirect", 32'd0, 32'(o_redirect));
	for (int k = 0; k <= num_vecs; k++) begin
		@(posedge i_clk);
		#1;
		if (k > 0) begin
			check_vector(k - 1);         // Line sampled at the edge just passed.
		end
		if (k < num_vecs) begin
			drive_vector(k);
		end else begin
			idle_inputs();
		end
	end
	$display("TEST PASSED");
	$finish;
end

// Ends a run that stops making progress.
initial begin
	wait (vectors_loaded);
	#((num_vecs + 20) * CLK_PERIOD);
	$display("Timeout: the vector replay did not finish in the expected time.");
	$display("TEST FAILED");
	$fatal(1, "Timeout.");
end

endmodule
